// File: common/tx_path_config.svh
`ifndef TX_PATH_CONFIG_SVH
`define TX_PATH_CONFIG_SVH

// ----------------------------------------------------------------------------
// Ring sizing
// ----------------------------------------------------------------------------

// Address width of the block ring
`define TX_RING_AW 6

// Slot count, must stay 2 ** TX_RING_AW
`define TX_RING_DEPTH 64

// ----------------------------------------------------------------------------
// Readiness hysteresis
// ----------------------------------------------------------------------------

// Stored blocks needed before the gearbox is switched on
`define TX_START_LEVEL 16

`endif

// File: common/tx_path_pkg.sv
package tx_path_pkg;

   // -------------------------------------------------------------------------
   // Host side word and line side block formats
   // -------------------------------------------------------------------------

   // One DMA write: two qwords, low qword goes out on the line first
   typedef struct packed {
      logic [1:0]   ctrl;    // One flag per qword, 1 marks a control block
      logic [127:0] data;
   } dma_word_t;

   // One 66-bit block as stored in the ring
   typedef struct packed {
      logic [1:0]  sync;
      logic [63:0] payload;  // Bit 0 leaves right after the sync header
   } tx_block_t;

   // Sync headers, bit 0 is sent first
   localparam logic [1:0] SYNC_DATA = 2'b01;
   localparam logic [1:0] SYNC_CTRL = 2'b10;

   // Word handed to the serializer each valid cycle
   typedef logic [39:0] line_word_t;

endpackage

// File: tx_ring/tx_block_ring.sv
`include "tx_path_config.svh"

module tx_block_ring import tx_path_pkg::*; (
   input  logic                 rd_clock,
   input  logic                 reset,
   input  tx_block_t            blk_wr,
   input  logic                 blk_wr_en,
   output tx_block_t            blk_rd,
   input  logic                 blk_rd_req,
   output logic                 empty,
   output logic [`TX_RING_AW:0] used
);

   localparam logic [`TX_RING_AW:0] DEPTH_W = `TX_RING_DEPTH;

   tx_block_t              mem [`TX_RING_DEPTH];
   logic [`TX_RING_AW-1:0] wr_ptr;
   logic [`TX_RING_AW-1:0] rd_ptr;
   logic                   full;
   logic                   wr_fire;
   logic                   rd_fire;

   // ------------------------------------------------------------------------
   // Flags
   // ------------------------------------------------------------------------

   assign empty = (used == '0);
   assign full  = (used == DEPTH_W);

   // Guard pointers against overrun and underrun
   assign wr_fire = blk_wr_en && !full;
   assign rd_fire = blk_rd_req && !empty;

   // Show-ahead: head block always on the read port
   assign blk_rd = mem[rd_ptr];

   // ------------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------------

   always_ff @(posedge rd_clock) begin
      if (wr_fire) begin
         mem[wr_ptr] <= blk_wr;
      end
   end

   // ------------------------------------------------------------------------
   // Pointers and fill level
   // ------------------------------------------------------------------------

   // Pointers wrap naturally at the ring depth
   always_ff @(posedge rd_clock or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Simultaneous read and write leaves the count unchanged
   always_ff @(posedge rd_clock or posedge reset) begin
      if (reset) begin
         used <= '0;
      end else begin
         case ({wr_fire, rd_fire})
            2'b10:   used <= used + 1'b1;
            2'b01:   used <= used - 1'b1;
            default: used <= used;
         endcase
      end
   end

endmodule

// File: design/tx_word_unpacker.sv
`include "tx_path_config.svh"

module tx_word_unpacker import tx_path_pkg::*; (
   input  logic                 rd_clock,
   input  logic                 reset,
   input  dma_word_t            dma_in,
   input  logic                 dma_valid,
   output logic                 dma_ready,
   input  logic [`TX_RING_AW:0] ring_used,
   output tx_block_t            blk_wr,
   output logic                 blk_wr_en
);

   localparam logic [`TX_RING_AW:0] DEPTH_W = `TX_RING_DEPTH;

   logic                 accept;
   logic                 hi_pending;
   tx_block_t            hi_blk;
   logic [`TX_RING_AW:0] free_slots;

   // Build one block from a qword and its control flag
   function automatic tx_block_t make_block(input logic ctrl, input logic [63:0] qword);
      tx_block_t blk;
      blk.sync    = ctrl ? SYNC_CTRL : SYNC_DATA;
      blk.payload = qword;
      return blk;
   endfunction

   // Free slots, minus the block already on its way into the ring
   assign free_slots = DEPTH_W - ring_used - {{`TX_RING_AW{1'b0}}, blk_wr_en};

   // Room for both halves, and nothing left over from the last word
   assign dma_ready = !hi_pending && (free_slots >= 2);
   assign accept    = dma_valid && dma_ready;

   // Write sequence: low block at the next edge, high block one edge later
   always_ff @(posedge rd_clock or posedge reset) begin
      if (reset) begin
         hi_pending <= 1'b0;
         blk_wr_en  <= 1'b0;
      end else begin
         blk_wr_en  <= accept | hi_pending;
         hi_pending <= accept;
      end
   end

   // Block registers
   always_ff @(posedge rd_clock) begin
      if (accept) begin
         blk_wr <= make_block(dma_in.ctrl[0], dma_in.data[63:0]);
         hi_blk <= make_block(dma_in.ctrl[1], dma_in.data[127:64]);
      end else if (hi_pending) begin
         blk_wr <= hi_blk;
      end
   end

endmodule

// File: design/tx_ready_ctl.sv
`include "tx_path_config.svh"

module tx_ready_ctl import tx_path_pkg::*; (
   input  logic                 rd_clock,
   input  logic                 reset,
   input  logic [`TX_RING_AW:0] used,
   output logic                 gearbox_ena
);

   localparam logic [`TX_RING_AW:0] START_W = `TX_START_LEVEL;

   logic level_high;
   logic level_zero;

   assign level_high = (used >= START_W);
   assign level_zero = (used == '0);

   // Hysteresis keeps the line fed for a whole burst
   // Switch on at the start level, switch off only when fully drained
   always_ff @(posedge rd_clock or posedge reset) begin
      if (reset) begin
         gearbox_ena <= 1'b0;
      end else if (!gearbox_ena) begin
         if (level_high) begin
            gearbox_ena <= 1'b1;
         end
      end else begin
         if (level_zero) begin
            gearbox_ena <= 1'b0;
         end
      end
   end

endmodule

// File: design/gearbox_66_40.sv
module gearbox_66_40 import tx_path_pkg::*; (
   input  logic       rd_clock,
   input  logic       reset,
   input  logic       gearbox_ena,
   input  logic       link_enable,
   input  tx_block_t  blk_rd,
   input  logic       empty,
   output logic       blk_rd_req,
   output line_word_t tx_data,
   output logic       tx_valid
);

   // Up to 39 held bits plus one fresh block
   localparam int BUF_W = 105;

   logic [BUF_W-1:0] bits_q;
   logic [6:0]       fill_q;
   logic             active;
   logic [65:0]      blk_bits;
   logic [BUF_W-1:0] blk_ext;
   logic [BUF_W-1:0] merged;
   logic [6:0]       fill_merged;
   logic             emit;

   // ------------------------------------------------------------------------
   // Take and emit decision
   // ------------------------------------------------------------------------

   assign active = gearbox_ena && link_enable;

   // Only pull a block when short of one line word
   assign blk_rd_req = active && (fill_q < 7'd40) && !empty;

   // Line order, LSB first: sync header, then payload
   assign blk_bits = {blk_rd.payload, blk_rd.sync};
   assign blk_ext  = {{(BUF_W - 66){1'b0}}, blk_bits};

   // New block lands just above the held bits
   assign merged      = blk_rd_req ? (bits_q | (blk_ext << fill_q)) : bits_q;
   assign fill_merged = blk_rd_req ? (fill_q + 7'd66) : fill_q;

   assign emit = active && (fill_merged >= 7'd40);

   // ------------------------------------------------------------------------
   // Bit buffer
   // ------------------------------------------------------------------------

   // Bits above fill_q stay zero so the OR merge is clean
   always_ff @(posedge rd_clock or posedge reset) begin
      if (reset) begin
         bits_q <= '0;
         fill_q <= '0;
      end else if (emit) begin
         bits_q <= merged >> 40;
         fill_q <= fill_merged - 7'd40;
      end else begin
         // Held bits survive a stall or disable
         bits_q <= merged;
         fill_q <= fill_merged;
      end
   end

   // ------------------------------------------------------------------------
   // Line output
   // ------------------------------------------------------------------------

   // Oldest 40 bits leave first, zeros when idle
   always_ff @(posedge rd_clock or posedge reset) begin
      if (reset) begin
         tx_data  <= '0;
         tx_valid <= 1'b0;
      end else if (emit) begin
         tx_data  <= merged[39:0];
         tx_valid <= 1'b1;
      end else begin
         tx_data  <= '0;
         tx_valid <= 1'b0;
      end
   end

endmodule

// File: design/sonic_tx_path.sv
`include "tx_path_config.svh"

module sonic_tx_path import tx_path_pkg::*; (
   input  logic                 rd_clock,
   input  logic                 reset,
   input  dma_word_t            dma_in,
   input  logic                 dma_valid,
   output logic                 dma_ready,
   input  logic                 link_enable,
   output line_word_t           tx_data,
   output logic                 tx_valid,
   output logic                 gearbox_ena,
   output logic [`TX_RING_AW:0] ring_level
);

   tx_block_t            blk_wr;
   logic                 blk_wr_en;
   tx_block_t            blk_rd;
   logic                 blk_rd_req;
   logic                 ring_empty;
   logic [`TX_RING_AW:0] ring_used;

   assign ring_level = ring_used;

   // ------------------------------------------------------------------------
   // Producer: DMA words into blocks
   // ------------------------------------------------------------------------

   tx_word_unpacker u_unpacker (
      .rd_clock  (rd_clock),
      .reset     (reset),
      .dma_in    (dma_in),
      .dma_valid (dma_valid),
      .dma_ready (dma_ready),
      .ring_used (ring_used),
      .blk_wr    (blk_wr),
      .blk_wr_en (blk_wr_en)
   );

   // Block storage
   tx_block_ring u_ring (
      .rd_clock   (rd_clock),
      .reset      (reset),
      .blk_wr     (blk_wr),
      .blk_wr_en  (blk_wr_en),
      .blk_rd     (blk_rd),
      .blk_rd_req (blk_rd_req),
      .empty      (ring_empty),
      .used       (ring_used)
   );

   // Holds the line off until enough blocks are stored
   tx_ready_ctl u_ready (
      .rd_clock    (rd_clock),
      .reset       (reset),
      .used        (ring_used),
      .gearbox_ena (gearbox_ena)
   );

   // ------------------------------------------------------------------------
   // Consumer: blocks onto the 40-bit line
   // ------------------------------------------------------------------------

   gearbox_66_40 u_gearbox (
      .rd_clock    (rd_clock),
      .reset       (reset),
      .gearbox_ena (gearbox_ena),
      .link_enable (link_enable),
      .blk_rd      (blk_rd),
      .empty       (ring_empty),
      .blk_rd_req  (blk_rd_req),
      .tx_data     (tx_data),
      .tx_valid    (tx_valid)
   );

endmodule

// File: verif/sonic_tx_path_assert.sv
`include "tx_path_config.svh"

module sonic_tx_path_assert (
   input logic                 rd_clock,
   input logic                 reset,
   input logic                 blk_wr_en,
   input logic [`TX_RING_AW:0] ring_used,
   input logic                 blk_rd_req,
   input logic                 dma_valid,
   input logic                 dma_ready,
   input logic                 tx_valid,
   input logic                 gearbox_ena
);

   timeunit 1ns;
   timeprecision 1ps;

   // Count of failed properties, read by the testbench at the end
   int violations;

   // Blocks in the ring, counted from the write and read strobes alone
   logic [`TX_RING_AW:0] blocks_held;

   initial violations = 0;

   always_ff @(posedge rd_clock or posedge reset) begin
      if (reset) begin
         blocks_held <= '0;
      end else begin
         blocks_held <= blocks_held + {{`TX_RING_AW{1'b0}}, blk_wr_en}
                        - {{`TX_RING_AW{1'b0}}, blk_rd_req};
      end
   end

   // Unpacker must never push into a full ring
   a_no_write_full : assert property (@(posedge rd_clock) disable iff (reset)
      blk_wr_en |-> (ring_used != (`TX_RING_AW+1)'(`TX_RING_DEPTH)))
      else begin
         violations++;
         $error("Ring written while full");
      end

   // Gearbox pulls only while a written block is still unread
   a_no_read_empty : assert property (@(posedge rd_clock) disable iff (reset)
      blk_rd_req |-> (blocks_held != '0))
      else begin
         violations++;
         $error("Ring read while empty");
      end

   // A line word needs the gearbox enabled one cycle earlier
   a_valid_needs_ena : assert property (@(posedge rd_clock) disable iff (reset)
      tx_valid |-> $past(gearbox_ena))
      else begin
         violations++;
         $error("Line word sent without gearbox enable");
      end

   // High block still pending right after an accept
   a_ready_drops : assert property (@(posedge rd_clock) disable iff (reset)
      (dma_valid && dma_ready) |=> !dma_ready)
      else begin
         violations++;
         $error("DMA ready stayed high after an accept");
      end

endmodule

// File: verif/tb_sonic_tx_path.sv
`include "tx_path_config.svh"

module tb_sonic_tx_path import tx_path_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   // Cycle budgets per test, generous against the worst drain time
   localparam int BUDGET_CYCLES = 40 + 10 + 200 + 250 + 500 + 800;

   logic                 rd_clock;
   logic                 reset;
   dma_word_t            dma_in;
   logic                 dma_valid;
   logic                 dma_ready;
   logic                 link_enable;
   line_word_t           tx_data;
   logic                 tx_valid;
   logic                 gearbox_ena;
   logic [`TX_RING_AW:0] ring_level;

   bit         exp_bits[$];
   line_word_t exp_word;
   logic [31:0] lcg_state;
   string      test_name;
   int         errors;
   int         err_mark;
   int         tests_passed;
   int         tests_failed;
   int         stuck;

   sonic_tx_path dut (.*);

   bind sonic_tx_path sonic_tx_path_assert u_assert (
      .rd_clock(rd_clock), .reset(reset), .blk_wr_en(blk_wr_en), .ring_used(ring_used),
      .blk_rd_req(blk_rd_req), .dma_valid(dma_valid),
      .dma_ready(dma_ready), .tx_valid(tx_valid), .gearbox_ena(gearbox_ena)
   );

   always #2 rd_clock = ~rd_clock;

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic dma_word_t random_word();
      dma_word_t   w;
      logic [31:0] r;
      w.data = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      r      = lcg_next();
      w.ctrl = r[9:8];
      return w;
   endfunction

   // Line order: sync header bit 0 first, then payload bit 0 upward
   task automatic queue_block(input logic ctrl, input logic [63:0] qword);
      logic [1:0] sync;
      sync = ctrl ? 2'b10 : 2'b01;
      exp_bits.push_back(sync[0]);
      exp_bits.push_back(sync[1]);
      for (int i = 0; i < 64; i++) begin
         exp_bits.push_back(qword[i]);
      end
   endtask

   // Hold valid until ready is seen, the accept lands on the next edge
   task automatic send_word(input dma_word_t w);
      @(posedge rd_clock);
      dma_in    <= w;
      dma_valid <= 1'b1;
      @(negedge rd_clock);
      while (!dma_ready) begin
         @(negedge rd_clock);
      end
      @(posedge rd_clock);
      dma_valid <= 1'b0;
      queue_block(w.ctrl[0], w.data[63:0]);
      queue_block(w.ctrl[1], w.data[127:64]);
   endtask

   task automatic check_equal(input string what, input int exp, input int act);
      assert (exp == act) else begin
         $display("[ERROR] %s: %s expected %0d, actual %0d", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic require_true(input bit ok, input string msg);
      assert (ok) else begin
         $display("%s: %s", test_name, msg);
         errors++;
      end
   endtask

   task automatic mark_start(input string name);
      test_name = name;
      err_mark  = errors;
   endtask

   task automatic report_result();
      if (errors == err_mark) begin
         tests_passed++;
         $display("PASS %s", test_name);
      end else begin
         tests_failed++;
         $display("FAIL %s (%0d errors)", test_name, errors - err_mark);
      end
   endtask

   // Gearbox switches off only once the ring is empty
   task automatic wait_drain();
      @(negedge rd_clock);
      while (gearbox_ena) begin
         @(negedge rd_clock);
      end
      @(negedge rd_clock);
      check_equal("ring_level", 0, int'(ring_level));
      require_true(exp_bits.size() < 40, "a full line word of expected bits was never sent");
   endtask

   // ------------------------------------------------------------------------
   // Line monitor, pops 40 expected bits per valid word
   // ------------------------------------------------------------------------

   always @(negedge rd_clock) begin
      if (!reset && tx_valid) begin
         if (exp_bits.size() < 40) begin
            $display("%s: line word sent with fewer than 40 bits expected", test_name);
            errors++;
         end else begin
            for (int i = 0; i < 40; i++) begin
               exp_word[i] = exp_bits.pop_front();
            end
            assert (tx_data === exp_word) else begin
               $display("[ERROR] %s: expected %h, actual %h", test_name, exp_word, tx_data);
               errors++;
            end
         end
      end else if (!reset) begin
         // Line stays at zero between valid words
         assert (tx_data === '0) else begin
            $display("[ERROR] %s: idle tx_data expected %h, actual %h",
                     test_name, 40'h0, tx_data);
            errors++;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------

   task automatic reset_state();
      mark_start("reset_state");
      @(negedge rd_clock);
      check_equal("dma_ready", 1, int'(dma_ready));
      check_equal("gearbox_ena", 0, int'(gearbox_ena));
      check_equal("tx_valid", 0, int'(tx_valid));
      check_equal("ring_level", 0, int'(ring_level));
      report_result();
   endtask

   task automatic below_threshold();
      bit line_active;
      mark_start("below_threshold");
      line_active = 1'b0;
      repeat (7) send_word(random_word());
      repeat (100) begin
         @(negedge rd_clock);
         line_active |= gearbox_ena | tx_valid;
      end
      require_true(!line_active, "gearbox started below the start level");
      check_equal("ring_level", 14, int'(ring_level));
      report_result();
   endtask

   task automatic start_and_drain();
      dma_word_t w;
      mark_start("start_and_drain");
      w      = random_word();
      w.ctrl = 2'b11;
      send_word(w);
      // Enable follows the level by one cycle
      @(negedge rd_clock);
      while (ring_level < `TX_START_LEVEL) begin
         @(negedge rd_clock);
      end
      check_equal("gearbox_ena", 0, int'(gearbox_ena));
      @(negedge rd_clock);
      check_equal("gearbox_ena", 1, int'(gearbox_ena));
      check_equal("ring_level", `TX_START_LEVEL, int'(ring_level));
      wait_drain();
      report_result();
   endtask

   task automatic line_stall();
      bit line_active;
      mark_start("line_stall");
      line_active = 1'b0;
      @(posedge rd_clock);
      link_enable <= 1'b0;
      repeat (20) send_word(random_word());
      repeat (50) begin
         @(negedge rd_clock);
         line_active |= tx_valid;
      end
      require_true(!line_active, "line word sent while the link was stalled");
      check_equal("ring_level", 40, int'(ring_level));
      @(posedge rd_clock);
      link_enable <= 1'b1;
      wait_drain();
      report_result();
   endtask

   task automatic back_pressure();
      mark_start("back_pressure");
      @(posedge rd_clock);
      link_enable <= 1'b0;
      fork
         repeat (40) send_word(random_word());
         begin
            // Host held off for 10 cycles means the ring is full
            stuck = 0;
            while (stuck < 10) begin
               @(negedge rd_clock);
               stuck = (dma_valid && !dma_ready) ? stuck + 1 : 0;
            end
            check_equal("ring_level", `TX_RING_DEPTH, int'(ring_level));
            @(posedge rd_clock);
            link_enable <= 1'b1;
         end
      join
      wait_drain();
      report_result();
   endtask

   // ------------------------------------------------------------------------
   // Main sequence and watchdog
   // ------------------------------------------------------------------------

   initial begin
      rd_clock     = 1'b0;
      reset        = 1'b1;
      dma_in       = '0;
      dma_valid    = 1'b0;
      link_enable  = 1'b1;
      lcg_state    = 32'haf66896e;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      test_name    = "reset";
      repeat (16) @(posedge rd_clock);
      reset <= 1'b0;
      reset_state();
      below_threshold();
      start_and_drain();
      line_stall();
      back_pressure();
      if (dut.u_assert.violations != 0) begin
         $display("Bound assertions failed %0d times", dut.u_assert.violations);
         tests_failed++;
      end
      $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(BUDGET_CYCLES * 4);
      $display("Timeout in %s, the DUT stopped making progress", test_name);
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: sonic_tx_path.f
+incdir+common
common/tx_path_pkg.sv
tx_ring/tx_block_ring.sv
design/tx_word_unpacker.sv
design/tx_ready_ctl.sv
design/gearbox_66_40.sv
design/sonic_tx_path.sv
verif/sonic_tx_path_assert.sv
verif/tb_sonic_tx_path.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the TX path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sonic_tx_path \
   -f sonic_tx_path.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "All tests passed" <<< "$output"; then
   exit 0
fi
exit 1
